/* hw/bpu_pkg.sv */
// Predictor widths, vector typedefs, meta layout offsets and counter reset values
package bpu_pkg;

    // Widths
    localparam int ADDR_WIDTH   = 32;
    localparam int TAG_WIDTH    = 8;
    localparam int IDX_WIDTH    = 6;
    localparam int CTR_WIDTH    = 3;
    localparam int USEFUL_WIDTH = 2;
    localparam int BCTR_WIDTH   = 2;
    localparam int PROV_WIDTH   = 2;

    typedef logic [ADDR_WIDTH-1:0]   pc_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [IDX_WIDTH-1:0]    idx_t;
    typedef logic [CTR_WIDTH-1:0]    ctr_t;
    typedef logic [USEFUL_WIDTH-1:0] useful_t;
    typedef logic [BCTR_WIDTH-1:0]   bctr_t;
    typedef logic [PROV_WIDTH-1:0]   provider_t;

    // Provider codes
    localparam provider_t PROV_BASE = 2'd0;
    localparam provider_t PROV_T1   = 2'd1;
    localparam provider_t PROV_T2   = 2'd2;

    // Counter values after allocation and after reset
    localparam ctr_t  CTR_WEAK_TAKEN = 3'b100;
    localparam bctr_t BCTR_RESET     = 2'b01;

    ////////////////////////////////////////
    // Meta layout
    ////////////////////////////////////////

    // Per-table slice
    localparam int TM_HIT_BIT    = 0;
    localparam int TM_IDX_LSB    = TM_HIT_BIT + 1;
    localparam int TM_TAG_LSB    = TM_IDX_LSB + IDX_WIDTH;
    localparam int TM_CTR_LSB    = TM_TAG_LSB + TAG_WIDTH;
    localparam int TM_USEFUL_LSB = TM_CTR_LSB + CTR_WIDTH;
    localparam int TM_WIDTH      = TM_USEFUL_LSB + USEFUL_WIDTH;

    typedef logic [TM_WIDTH-1:0] tmeta_t;

    // Whole meta vector
    localparam int META_PROV_LSB = 0;
    localparam int META_T1_LSB   = META_PROV_LSB + PROV_WIDTH;
    localparam int META_T2_LSB   = META_T1_LSB + TM_WIDTH;
    localparam int META_BCTR_LSB = META_T2_LSB + TM_WIDTH;
    localparam int META_BIDX_LSB = META_BCTR_LSB + BCTR_WIDTH;
    localparam int META_PRED_BIT = META_BIDX_LSB + IDX_WIDTH;
    localparam int META_WIDTH    = META_PRED_BIT + 1;

    typedef logic [META_WIDTH-1:0] meta_t;

endpackage

/* hw/tage_update_if.sv */
// Update command bundle for one tagged table, policy and table modports
`timescale 1ns/1ps

interface tage_update_if;

    // Write strobe, takes effect at the clock edge
    logic               upd_valid;

    // Training controls
    logic               upd_ctr;
    logic               inc_ctr;
    logic               upd_useful;
    logic               inc_useful;
    logic               realloc;

    // Entry contents captured at prediction time
    bpu_pkg::ctr_t      old_ctr;
    bpu_pkg::useful_t   old_useful;
    bpu_pkg::tag_t      tag;
    bpu_pkg::idx_t      index;

    modport policy (
        output upd_valid, upd_ctr, inc_ctr, upd_useful, inc_useful, realloc,
        output old_ctr, old_useful, tag, index
    );

    modport tbl (
        input upd_valid, upd_ctr, inc_ctr, upd_useful, inc_useful, realloc,
        input old_ctr, old_useful, tag, index
    );

endinterface

/* hw/csr_hash.sv */
// Circular shift register fold of a history window into a short hash
`timescale 1ns/1ps

module csr_hash #(
    parameter int INPUT_LENGTH  = 8,
    parameter int OUTPUT_LENGTH = 6
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     push_i,
    input  logic                     new_bit_i,
    input  logic                     old_bit_i,
    output logic [OUTPUT_LENGTH-1:0] hash_o
);

    // Fold position of the bit leaving the window
    localparam int OUT_POS = INPUT_LENGTH % OUTPUT_LENGTH;

    logic [OUTPUT_LENGTH-1:0] hash_q;
    logic [OUTPUT_LENGTH-1:0] hash_next;

    always_comb begin
        // Rotate left by one
        hash_next = {hash_q[OUTPUT_LENGTH-2:0], hash_q[OUTPUT_LENGTH-1]};
        hash_next[0] = hash_next[0] ^ new_bit_i;
        // Cancel the oldest bit out of the fold
        hash_next[OUT_POS] = hash_next[OUT_POS] ^ old_bit_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hash_q <= '0;
        end else if (push_i) begin
            hash_q <= hash_next;
        end
    end

    assign hash_o = hash_q;

endmodule

/* hw/pht_ram.sv */
// Register array table memory with registered read port and write port
`timescale 1ns/1ps

module pht_ram #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 64
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output logic [DATA_WIDTH-1:0]    rdata_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [DATA_WIDTH-1:0]    wdata_i
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Read sees the old word when the same address is written
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[raddr_i];
            if (we_i) begin
                mem[waddr_i] <= wdata_i;
            end
        end
    end

endmodule

/* hw/base_predictor.sv */
// Bimodal base table of 2-bit counters with registered read and saturating update
`timescale 1ns/1ps

module base_predictor (
    input  logic               clk,
    input  logic               arst_n_i,
    input  bpu_pkg::pc_t       query_pc_i,
    output bpu_pkg::bctr_t     ctr_o,
    output bpu_pkg::idx_t      index_o,
    input  logic               upd_valid_i,
    input  logic               upd_taken_i,
    input  bpu_pkg::idx_t      upd_index_i,
    input  bpu_pkg::bctr_t     upd_ctr_i
);

    localparam int DEPTH = 1 << bpu_pkg::IDX_WIDTH;

    bpu_pkg::bctr_t cnt_mem [DEPTH];
    bpu_pkg::idx_t  query_idx;
    bpu_pkg::bctr_t new_ctr;

    // Word-aligned PC bits
    assign query_idx = query_pc_i[2 +: bpu_pkg::IDX_WIDTH];

    // Saturating step of the counter carried in the meta
    always_comb begin
        new_ctr = upd_ctr_i;
        if (upd_taken_i && upd_ctr_i != '1) begin
            new_ctr = upd_ctr_i + 1'b1;
        end else if (!upd_taken_i && upd_ctr_i != '0) begin
            new_ctr = upd_ctr_i - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt_mem[i] <= bpu_pkg::BCTR_RESET;
            end
            ctr_o   <= bpu_pkg::BCTR_RESET;
            index_o <= '0;
        end else begin
            ctr_o   <= cnt_mem[query_idx];
            index_o <= query_idx;
            if (upd_valid_i) begin
                cnt_mem[upd_index_i] <= new_ctr;
            end
        end
    end

endmodule

/* hw/tagged_predictor.sv */
// Tagged table with folded history index and tag, registered lookup and update
`timescale 1ns/1ps

module tagged_predictor #(
    parameter int HIST_LEN  = 4,
    parameter int PHT_DEPTH = 64
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  bpu_pkg::pc_t        query_pc_i,
    input  logic                hist_push_i,
    input  logic                hist_new_i,
    input  logic                hist_old_i,
    output logic                hit_o,
    output bpu_pkg::ctr_t       ctr_o,
    output bpu_pkg::useful_t    useful_o,
    output bpu_pkg::idx_t       index_o,
    output bpu_pkg::tag_t       tag_o,
    tage_update_if.tbl          upd
);

    // Entry is valid, counter, tag, useful
    localparam int ENTRY_WIDTH = 1 + bpu_pkg::CTR_WIDTH + bpu_pkg::TAG_WIDTH
                               + bpu_pkg::USEFUL_WIDTH;

    bpu_pkg::idx_t              idx_fold;
    bpu_pkg::tag_t              tag_fold1;
    logic [bpu_pkg::TAG_WIDTH-2:0] tag_fold2;
    bpu_pkg::idx_t              query_idx;
    bpu_pkg::idx_t              query_idx_q;
    bpu_pkg::tag_t              query_tag;
    bpu_pkg::tag_t              query_tag_q;
    logic [ENTRY_WIDTH-1:0]     rd_entry;
    logic [ENTRY_WIDTH-1:0]     wr_entry;
    logic                       rd_valid;
    bpu_pkg::tag_t              rd_tag;
    bpu_pkg::ctr_t              new_ctr;
    bpu_pkg::useful_t           new_useful;

    ////////////////////////////////////////
    // History folds
    ////////////////////////////////////////

    csr_hash #(
        .INPUT_LENGTH (HIST_LEN),
        .OUTPUT_LENGTH(bpu_pkg::IDX_WIDTH)
    ) idx_hash_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (hist_push_i),
        .new_bit_i(hist_new_i),
        .old_bit_i(hist_old_i),
        .hash_o   (idx_fold)
    );

    csr_hash #(
        .INPUT_LENGTH (HIST_LEN),
        .OUTPUT_LENGTH(bpu_pkg::TAG_WIDTH)
    ) tag_hash1_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (hist_push_i),
        .new_bit_i(hist_new_i),
        .old_bit_i(hist_old_i),
        .hash_o   (tag_fold1)
    );

    // One bit shorter so the two tag folds differ
    csr_hash #(
        .INPUT_LENGTH (HIST_LEN),
        .OUTPUT_LENGTH(bpu_pkg::TAG_WIDTH - 1)
    ) tag_hash2_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .push_i   (hist_push_i),
        .new_bit_i(hist_new_i),
        .old_bit_i(hist_old_i),
        .hash_o   (tag_fold2)
    );

    ////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////

    assign query_idx = idx_fold ^ query_pc_i[2 +: bpu_pkg::IDX_WIDTH]
                     ^ query_pc_i[2 + bpu_pkg::IDX_WIDTH +: bpu_pkg::IDX_WIDTH];
    assign query_tag = query_pc_i[2 +: bpu_pkg::TAG_WIDTH] ^ tag_fold1 ^ {tag_fold2, 1'b0};

    // Aligned with the RAM read
    always_ff @(posedge clk) begin
        query_idx_q <= query_idx;
        query_tag_q <= query_tag;
    end

    assign {rd_valid, ctr_o, rd_tag, useful_o} = rd_entry;
    assign hit_o   = rd_valid && (rd_tag == query_tag_q);
    assign index_o = query_idx_q;
    assign tag_o   = query_tag_q;

    ////////////////////////////////////////
    // Update
    ////////////////////////////////////////

    always_comb begin
        new_ctr    = upd.old_ctr;
        new_useful = upd.old_useful;
        if (upd.upd_ctr) begin
            if (upd.inc_ctr && upd.old_ctr != '1) begin
                new_ctr = upd.old_ctr + 1'b1;
            end else if (!upd.inc_ctr && upd.old_ctr != '0) begin
                new_ctr = upd.old_ctr - 1'b1;
            end
        end
        if (upd.upd_useful) begin
            if (upd.inc_useful && upd.old_useful != '1) begin
                new_useful = upd.old_useful + 1'b1;
            end else if (!upd.inc_useful && upd.old_useful != '0) begin
                new_useful = upd.old_useful - 1'b1;
            end
        end
        // Fresh entry starts weakly taken and not useful
        if (upd.realloc) begin
            new_ctr    = bpu_pkg::CTR_WEAK_TAKEN;
            new_useful = '0;
        end
    end

    assign wr_entry = {1'b1, new_ctr, upd.tag, new_useful};

    pht_ram #(
        .DATA_WIDTH(ENTRY_WIDTH),
        .DEPTH     (PHT_DEPTH)
    ) pht_i (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .raddr_i (query_idx),
        .rdata_o (rd_entry),
        .we_i    (upd.upd_valid),
        .waddr_i (upd.index),
        .wdata_i (wr_entry)
    );

endmodule

/* hw/tage_predictor.sv */
// TAGE predictor top with global history, provider choice, meta packing and update policy
`timescale 1ns/1ps

module tage_predictor #(
    parameter int PHT_DEPTH   = 64,
    parameter int T1_HIST_LEN = 4,
    parameter int T2_HIST_LEN = 8
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   query_valid_i,
    input  bpu_pkg::pc_t           query_pc_i,
    output logic                   pred_taken_o,
    output bpu_pkg::provider_t     pred_provider_o,
    output bpu_pkg::meta_t         pred_meta_o,
    input  logic                   upd_valid_i,
    input  logic                   upd_taken_i,
    input  bpu_pkg::pc_t           upd_pc_i,
    input  bpu_pkg::meta_t         upd_meta_i,
    input  logic                   hist_push_i,
    input  logic                   hist_taken_i
);

    logic [T2_HIST_LEN-1:0] ghr;
    logic                   query_valid_q;
    logic                   pred_raw;
    bpu_pkg::provider_t     provider;
    bpu_pkg::bctr_t         base_ctr;
    bpu_pkg::idx_t          base_idx;
    logic                   t1_hit, t2_hit;
    bpu_pkg::ctr_t          t1_ctr, t2_ctr;
    bpu_pkg::useful_t       t1_useful, t2_useful;
    bpu_pkg::idx_t          t1_idx, t2_idx;
    bpu_pkg::tag_t          t1_tag, t2_tag;

    // Update side decode
    bpu_pkg::provider_t     m_prov;
    bpu_pkg::tmeta_t        m1, m2;
    logic                   m_pred, mispred, base_pred, t1_pred;
    logic                   t1_lower, t2_lower, t1_alloc, t2_alloc;

    tage_update_if upd1_if ();
    tage_update_if upd2_if ();

    ////////////////////////////////////////
    // Global history
    ////////////////////////////////////////

    // Bit 0 is the newest outcome
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr           <= '0;
            query_valid_q <= 1'b0;
        end else begin
            query_valid_q <= query_valid_i;
            if (hist_push_i) begin
                ghr <= {ghr[T2_HIST_LEN-2:0], hist_taken_i};
            end
        end
    end

    base_predictor base_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .query_pc_i (query_pc_i),
        .ctr_o      (base_ctr),
        .index_o    (base_idx),
        .upd_valid_i(upd_valid_i && (m_prov == bpu_pkg::PROV_BASE)),
        .upd_taken_i(upd_taken_i),
        .upd_index_i(upd_meta_i[bpu_pkg::META_BIDX_LSB +: bpu_pkg::IDX_WIDTH]),
        .upd_ctr_i  (upd_meta_i[bpu_pkg::META_BCTR_LSB +: bpu_pkg::BCTR_WIDTH])
    );

    // Each table drops the oldest bit of its own window
    tagged_predictor #(.HIST_LEN(T1_HIST_LEN), .PHT_DEPTH(PHT_DEPTH)) t1_i (
        .clk(clk), .arst_n_i(arst_n_i), .query_pc_i(query_pc_i),
        .hist_push_i(hist_push_i), .hist_new_i(hist_taken_i),
        .hist_old_i(ghr[T1_HIST_LEN-1]),
        .hit_o(t1_hit), .ctr_o(t1_ctr), .useful_o(t1_useful),
        .index_o(t1_idx), .tag_o(t1_tag), .upd(upd1_if)
    );

    tagged_predictor #(.HIST_LEN(T2_HIST_LEN), .PHT_DEPTH(PHT_DEPTH)) t2_i (
        .clk(clk), .arst_n_i(arst_n_i), .query_pc_i(query_pc_i),
        .hist_push_i(hist_push_i), .hist_new_i(hist_taken_i),
        .hist_old_i(ghr[T2_HIST_LEN-1]),
        .hit_o(t2_hit), .ctr_o(t2_ctr), .useful_o(t2_useful),
        .index_o(t2_idx), .tag_o(t2_tag), .upd(upd2_if)
    );

    ////////////////////////////////////////
    // Provider choice and meta
    ////////////////////////////////////////

    // Longest history hit wins
    always_comb begin
        if (t2_hit) begin
            provider = bpu_pkg::PROV_T2;
            pred_raw = t2_ctr[bpu_pkg::CTR_WIDTH-1];
        end else if (t1_hit) begin
            provider = bpu_pkg::PROV_T1;
            pred_raw = t1_ctr[bpu_pkg::CTR_WIDTH-1];
        end else begin
            provider = bpu_pkg::PROV_BASE;
            pred_raw = base_ctr[bpu_pkg::BCTR_WIDTH-1];
        end
    end

    assign pred_taken_o    = query_valid_q && pred_raw;
    assign pred_provider_o = provider;

    always_comb begin
        pred_meta_o = '0;
        pred_meta_o[bpu_pkg::META_PROV_LSB +: bpu_pkg::PROV_WIDTH] = provider;
        pred_meta_o[bpu_pkg::META_T1_LSB +: bpu_pkg::TM_WIDTH] =
            {t1_useful, t1_ctr, t1_tag, t1_idx, t1_hit};
        pred_meta_o[bpu_pkg::META_T2_LSB +: bpu_pkg::TM_WIDTH] =
            {t2_useful, t2_ctr, t2_tag, t2_idx, t2_hit};
        pred_meta_o[bpu_pkg::META_BCTR_LSB +: bpu_pkg::BCTR_WIDTH] = base_ctr;
        pred_meta_o[bpu_pkg::META_BIDX_LSB +: bpu_pkg::IDX_WIDTH]  = base_idx;
        pred_meta_o[bpu_pkg::META_PRED_BIT] = pred_taken_o;
    end

    ////////////////////////////////////////
    // Update policy
    ////////////////////////////////////////

    assign m_prov    = upd_meta_i[bpu_pkg::META_PROV_LSB +: bpu_pkg::PROV_WIDTH];
    assign m1        = upd_meta_i[bpu_pkg::META_T1_LSB +: bpu_pkg::TM_WIDTH];
    assign m2        = upd_meta_i[bpu_pkg::META_T2_LSB +: bpu_pkg::TM_WIDTH];
    assign m_pred    = upd_meta_i[bpu_pkg::META_PRED_BIT];
    assign mispred   = (m_pred != upd_taken_i);
    assign base_pred = upd_meta_i[bpu_pkg::META_BCTR_LSB + bpu_pkg::BCTR_WIDTH - 1];
    assign t1_pred   = m1[bpu_pkg::TM_CTR_LSB + bpu_pkg::CTR_WIDTH - 1];

    // Next lower source behind each table
    assign t1_lower = base_pred;
    assign t2_lower = m1[bpu_pkg::TM_HIT_BIT] ? t1_pred : base_pred;

    // Allocate one table above the provider
    assign t1_alloc = mispred && (m_prov == bpu_pkg::PROV_BASE);
    assign t2_alloc = mispred && (m_prov == bpu_pkg::PROV_T1);

    assign upd1_if.upd_valid  = upd_valid_i && ((m_prov == bpu_pkg::PROV_T1) || t1_alloc);
    assign upd1_if.upd_ctr    = (m_prov == bpu_pkg::PROV_T1);
    assign upd1_if.inc_ctr    = upd_taken_i;
    assign upd1_if.upd_useful = (m_prov == bpu_pkg::PROV_T1) && (t1_lower != m_pred);
    assign upd1_if.inc_useful = !mispred;
    assign upd1_if.realloc    = t1_alloc;
    assign upd1_if.old_ctr    = m1[bpu_pkg::TM_CTR_LSB +: bpu_pkg::CTR_WIDTH];
    assign upd1_if.old_useful = m1[bpu_pkg::TM_USEFUL_LSB +: bpu_pkg::USEFUL_WIDTH];
    assign upd1_if.tag        = m1[bpu_pkg::TM_TAG_LSB +: bpu_pkg::TAG_WIDTH];
    assign upd1_if.index      = m1[bpu_pkg::TM_IDX_LSB +: bpu_pkg::IDX_WIDTH];

    assign upd2_if.upd_valid  = upd_valid_i && ((m_prov == bpu_pkg::PROV_T2) || t2_alloc);
    assign upd2_if.upd_ctr    = (m_prov == bpu_pkg::PROV_T2);
    assign upd2_if.inc_ctr    = upd_taken_i;
    assign upd2_if.upd_useful = (m_prov == bpu_pkg::PROV_T2) && (t2_lower != m_pred);
    assign upd2_if.inc_useful = !mispred;
    assign upd2_if.realloc    = t2_alloc;
    assign upd2_if.old_ctr    = m2[bpu_pkg::TM_CTR_LSB +: bpu_pkg::CTR_WIDTH];
    assign upd2_if.old_useful = m2[bpu_pkg::TM_USEFUL_LSB +: bpu_pkg::USEFUL_WIDTH];
    assign upd2_if.tag        = m2[bpu_pkg::TM_TAG_LSB +: bpu_pkg::TAG_WIDTH];
    assign upd2_if.index      = m2[bpu_pkg::TM_IDX_LSB +: bpu_pkg::IDX_WIDTH];

endmodule

/* verif/tb_tage_predictor.sv */
// Testbench for the TAGE predictor with step table, compare tasks, LFSR and watchdog
`timescale 1ns/1ps

module tb_tage_predictor;

    typedef enum int {OP_QUERY, OP_RQUERY, OP_UPDATE, OP_PUSH, OP_RESET} op_e;

    // Word-aligned PCs whose zero-history index is pc[7:2] and tag pc[9:2]
    localparam bpu_pkg::pc_t PC_A = 32'h0000_0040;
    localparam bpu_pkg::pc_t PC_B = 32'h0000_0080;
    localparam bpu_pkg::pc_t PC_D = 32'h0000_00c0;

    logic               clk;
    logic               arst_n_i;
    logic               query_valid_i;
    bpu_pkg::pc_t       query_pc_i;
    logic               pred_taken_o;
    bpu_pkg::provider_t pred_provider_o;
    bpu_pkg::meta_t     pred_meta_o;
    logic               upd_valid_i;
    logic               upd_taken_i;
    bpu_pkg::pc_t       upd_pc_i;
    bpu_pkg::meta_t     upd_meta_i;
    logic               hist_push_i;
    logic               hist_taken_i;

    // Step table columns
    string              st_name[$];
    op_e                st_op[$];
    bpu_pkg::pc_t       st_pc[$];
    logic               st_bit[$];
    int                 st_count[$];
    logic               st_exp_taken[$];
    bpu_pkg::provider_t st_exp_prov[$];

    logic [31:0]        lfsr_state;
    bpu_pkg::meta_t     last_meta;
    bpu_pkg::pc_t       last_pc;
    int                 num_checks;
    int                 num_errors;
    logic               table_ready;

    tage_predictor #(
        .PHT_DEPTH  (64),
        .T1_HIST_LEN(4),
        .T2_HIST_LEN(8)
    ) dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .query_valid_i  (query_valid_i),
        .query_pc_i     (query_pc_i),
        .pred_taken_o   (pred_taken_o),
        .pred_provider_o(pred_provider_o),
        .pred_meta_o    (pred_meta_o),
        .upd_valid_i    (upd_valid_i),
        .upd_taken_i    (upd_taken_i),
        .upd_pc_i       (upd_pc_i),
        .upd_meta_i     (upd_meta_i),
        .hist_push_i    (hist_push_i),
        .hist_taken_i   (hist_taken_i)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_pc(output bpu_pkg::pc_t pc);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            pc[i] = lfsr_state[0];
        end
    endtask

    task automatic add_step(input string name, input op_e op, input bpu_pkg::pc_t pc,
                            input logic bit_v, input int count, input logic exp_taken,
                            input bpu_pkg::provider_t exp_prov);
        st_name.push_back(name);
        st_op.push_back(op);
        st_pc.push_back(pc);
        st_bit.push_back(bit_v);
        st_count.push_back(count);
        st_exp_taken.push_back(exp_taken);
        st_exp_prov.push_back(exp_prov);
    endtask

    task automatic check_taken(input string name, input logic exp, input logic act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("FAIL %s taken expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic check_provider(input string name, input bpu_pkg::provider_t exp,
                                  input bpu_pkg::provider_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("FAIL %s provider expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input bpu_pkg::idx_t exp,
                               input bpu_pkg::idx_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("FAIL %s base index expected %0d actual %0d", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Step table
    ////////////////////////////////////////

    task automatic build_table();
        // Empty tables leave base weakly not taken
        add_step("rand_q0", OP_RQUERY, '0, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("rand_q1", OP_RQUERY, '0, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("rand_q2", OP_RQUERY, '0, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("idle_qa", OP_QUERY, PC_A, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        // Base miss allocates table 1 entry 32 with tag 8'h20
        add_step("base_q0", OP_QUERY, PC_B, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("base_u0", OP_UPDATE, PC_B, 1'b1, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("alloc_q1", OP_QUERY, PC_B, 1'b0, 1, 1'b1, bpu_pkg::PROV_T1);
        // Table 1 counter on D whose miss allocates table 2 entry 48
        add_step("ctr_q0", OP_QUERY, PC_D, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("ctr_u0", OP_UPDATE, PC_D, 1'b1, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("ctr_q1", OP_QUERY, PC_D, 1'b0, 1, 1'b1, bpu_pkg::PROV_T1);
        add_step("ctr_u1", OP_UPDATE, PC_D, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("ctr_q2", OP_QUERY, PC_D, 1'b0, 1, 1'b1, bpu_pkg::PROV_T2);
        // One taken bit moves B onto empty rows 33 where base alone decides
        add_step("push_one", OP_PUSH, '0, 1'b1, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("base_q1", OP_QUERY, PC_B, 1'b0, 1, 1'b1, bpu_pkg::PROV_BASE);
        add_step("base_u1", OP_UPDATE, PC_B, 1'b1, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("base_q2", OP_QUERY, PC_B, 1'b0, 1, 1'b1, bpu_pkg::PROV_BASE);
        // Short window back to zero while the long window still holds the one
        add_step("push_z4a", OP_PUSH, '0, 1'b0, 4, 1'b0, bpu_pkg::PROV_BASE);
        add_step("ctr_q3", OP_QUERY, PC_D, 1'b0, 1, 1'b0, bpu_pkg::PROV_T1);
        add_step("ctr_u3", OP_UPDATE, PC_D, 1'b1, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("ctr_q4", OP_QUERY, PC_D, 1'b0, 1, 1'b1, bpu_pkg::PROV_T2);
        add_step("push_z4b", OP_PUSH, '0, 1'b0, 4, 1'b0, bpu_pkg::PROV_BASE);
        // Zeros onto zero history leave every fold alone
        add_step("push_z8", OP_PUSH, '0, 1'b0, 8, 1'b0, bpu_pkg::PROV_BASE);
        add_step("hist_q0", OP_QUERY, PC_B, 1'b0, 1, 1'b1, bpu_pkg::PROV_T1);
        add_step("hist_q1", OP_QUERY, PC_D, 1'b0, 1, 1'b1, bpu_pkg::PROV_T2);
        add_step("reset", OP_RESET, '0, 1'b0, 2, 1'b0, bpu_pkg::PROV_BASE);
        add_step("rst_qa", OP_QUERY, PC_A, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("rst_qb", OP_QUERY, PC_B, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
        add_step("rst_qd", OP_QUERY, PC_D, 1'b0, 1, 1'b0, bpu_pkg::PROV_BASE);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic run_step(input int i);
        int           err_before;
        bpu_pkg::pc_t pc;
        string        meta_name;
        err_before = num_errors;
        pc = st_pc[i];
        case (st_op[i])
            OP_QUERY, OP_RQUERY: begin
                if (st_op[i] == OP_RQUERY) begin
                    draw_pc(pc);
                end
                query_valid_i = 1'b1;
                query_pc_i    = pc;
                @(posedge clk);
                #1;
                query_valid_i = 1'b0;
                check_taken(st_name[i], st_exp_taken[i], pred_taken_o);
                check_provider(st_name[i], st_exp_prov[i], pred_provider_o);
                // Meta carries the same choice and the base row of the PC
                meta_name = {st_name[i], " meta"};
                check_provider(meta_name, st_exp_prov[i],
                               pred_meta_o[bpu_pkg::META_PROV_LSB +: bpu_pkg::PROV_WIDTH]);
                check_taken(meta_name, st_exp_taken[i], pred_meta_o[bpu_pkg::META_PRED_BIT]);
                check_index(meta_name, pc[7:2],
                            pred_meta_o[bpu_pkg::META_BIDX_LSB +: bpu_pkg::IDX_WIDTH]);
                last_meta = pred_meta_o;
                last_pc   = pc;
                if (num_errors == err_before) begin
                    $display("PASS %s pc %h provider %0d taken %0b", st_name[i], pc,
                             pred_provider_o, pred_taken_o);
                end
            end
            OP_UPDATE: begin
                upd_valid_i = 1'b1;
                upd_taken_i = st_bit[i];
                upd_pc_i    = last_pc;
                upd_meta_i  = last_meta;
                @(posedge clk);
                #1;
                upd_valid_i = 1'b0;
            end
            OP_PUSH: begin
                hist_push_i  = 1'b1;
                hist_taken_i = st_bit[i];
                repeat (st_count[i]) @(posedge clk);
                #1;
                hist_push_i = 1'b0;
            end
            default: begin
                arst_n_i = 1'b0;
                repeat (st_count[i]) @(posedge clk);
                #1;
                arst_n_i = 1'b1;
            end
        endcase
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        arst_n_i      = 1'b0;
        query_valid_i = 1'b0;
        query_pc_i    = '0;
        upd_valid_i   = 1'b0;
        upd_taken_i   = 1'b0;
        upd_pc_i      = '0;
        upd_meta_i    = '0;
        hist_push_i   = 1'b0;
        hist_taken_i  = 1'b0;
        lfsr_state    = 32'h77c7;
        last_meta     = '0;
        last_pc       = '0;
        num_checks    = 0;
        num_errors    = 0;
        table_ready   = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        for (int i = 0; i < st_op.size(); i++) begin
            run_step(i);
        end
        $display("Checks run %0d, failed %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = 20 * st_op.size() + 10;
        repeat (limit) @(posedge clk);
        $display("ERROR watchdog expired after %0d cycles, step table did not finish", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tage_predictor.f */
hw/bpu_pkg.sv
hw/tage_update_if.sv
hw/csr_hash.sv
hw/pht_ram.sv
hw/base_predictor.sv
hw/tagged_predictor.sv
hw/tage_predictor.sv
verif/tb_tage_predictor.sv

/* Bender.yml */
package:
  name: tage_predictor

sources:
  - hw/bpu_pkg.sv
  - hw/tage_update_if.sv
  - hw/csr_hash.sv
  - hw/pht_ram.sv
  - hw/base_predictor.sv
  - hw/tagged_predictor.sv
  - hw/tage_predictor.sv
  - target: test
    files:
      - verif/tb_tage_predictor.sv
